// ==== hw/pkt_chk_pkg.sv ====
/* Packet checker shared definitions */

package pkt_chk_pkg;

    ////////////////////////////////////////
    // Sizes

    localparam int word_bytes = 8;
    localparam int mtu_bytes  = 64;
    localparam int mtu_words  = mtu_bytes / word_bytes;
    localparam int max_pkts   = 8;

    localparam int pkt_id_bits    = 4;
    localparam int match_cnt_bits = 16;

    ////////////////////////////////////////
    // Vector types

    // One stream word and its byte enables
    typedef logic [word_bytes*8-1:0] data_t;
    typedef logic [word_bytes-1:0]   keep_t;

    typedef logic [$clog2(mtu_words)-1:0]   word_idx_t;
    // Holds 0 up to the full MTU
    typedef logic [$clog2(mtu_bytes+1)-1:0] blen_t;
    typedef logic [pkt_id_bits-1:0]         pkt_id_t;

    typedef logic [$clog2(max_pkts)-1:0]    entry_idx_t;
    typedef logic [$clog2(max_pkts+1)-1:0]  entry_cnt_t;
    typedef logic [match_cnt_bits-1:0]      match_cnt_t;

    ////////////////////////////////////////
    // Matcher FSM

    typedef enum logic [2:0] {
        st_idle,
        st_entry_check,
        st_word_compare,
        st_report_match,
        st_report_miss,
        st_release
    } match_state_t;

endpackage

// ==== hw/rx_frame_if.sv ====
/* Held frame link */

`timescale 1ns/10ps

interface rx_frame_if import pkt_chk_pkg::*; ();

    // Frame side, owned by the assembler
    logic      frame_ready;
    blen_t     frame_len;
    pkt_id_t   frame_id;
    data_t     rd_word;

    // Read index and handback from the matcher
    word_idx_t rd_word_idx;
    logic      frame_release;

    modport assembler (
        output frame_ready, frame_len, frame_id, rd_word,
        input  rd_word_idx, frame_release
    );

    modport matcher (
        input  frame_ready, frame_len, frame_id, rd_word,
        output rd_word_idx, frame_release
    );

endinterface

// ==== hw/pkt_assembler.sv ====
/* Stream frame assembler */

`timescale 1ns/10ps

module pkt_assembler import pkt_chk_pkg::*; (
    input  logic          axis_packet_in_monitor,
    input  logic          reset,
    input  logic          tvalid,
    input  logic          tlast,
    input  data_t         tdata,
    input  keep_t         tkeep,
    input  pkt_id_t       packet_in_id,
    output logic          tready,
    rx_frame_if.assembler frame
);

    data_t     frame_buf [mtu_words];
    word_idx_t wr_idx;
    logic      frame_held;
    blen_t     held_len;
    pkt_id_t   held_id;
    logic      accept;

    // Number of valid bytes in one word
    function automatic blen_t keep_bytes(input keep_t keep);
        blen_t n;
        n = '0;
        for (int i = 0; i < word_bytes; i++) begin
            n = n + blen_t'(keep[i]);
        end
        return n;
    endfunction

    // Stall the stream while a frame is being matched
    assign tready = !frame_held;
    assign accept = tvalid && tready;

    always_ff @(posedge axis_packet_in_monitor) begin
        if (accept) begin
            frame_buf[wr_idx] <= tdata;
        end
        if (accept && tlast) begin
            held_len <= blen_t'(wr_idx) * blen_t'(word_bytes) + keep_bytes(tkeep);
            held_id  <= packet_in_id;
        end
    end

    always_ff @(posedge axis_packet_in_monitor) begin
        if (reset) begin
            wr_idx     <= '0;
            frame_held <= 1'b0;
        end else if (accept) begin
            if (tlast) begin
                wr_idx     <= '0;
                frame_held <= 1'b1;
            end else begin
                wr_idx <= wr_idx + word_idx_t'(1);
            end
        end else if (frame.frame_release) begin
            frame_held <= 1'b0;
        end
    end

    assign frame.frame_ready = frame_held;
    assign frame.frame_len   = held_len;
    assign frame.frame_id    = held_id;
    assign frame.rd_word     = frame_buf[frame.rd_word_idx];

endmodule

// ==== hw/expected_table.sv ====
/* Expected packet table */

`timescale 1ns/10ps

module expected_table import pkt_chk_pkg::*; (
    input  logic       axis_packet_in_monitor,
    input  logic       load_en,
    input  logic       load_len_en,
    input  entry_idx_t load_entry,
    input  word_idx_t  load_word,
    input  data_t      load_data,
    input  blen_t      load_len,
    input  pkt_id_t    load_id,
    input  entry_idx_t entry_idx,
    input  word_idx_t  word_idx,
    output data_t      entry_word,
    output blen_t      entry_len,
    output pkt_id_t    entry_id
);

    ////////////////////////////////////////
    // Storage

    data_t   word_mem [max_pkts][mtu_words];
    blen_t   len_mem  [max_pkts];
    pkt_id_t id_mem   [max_pkts];

    ////////////////////////////////////////
    // Load port

    // Payload words, one per strobe
    always_ff @(posedge axis_packet_in_monitor) begin
        if (load_en) begin
            word_mem[load_entry][load_word] <= load_data;
        end
    end

    // Entry header
    always_ff @(posedge axis_packet_in_monitor) begin
        if (load_len_en) begin
            len_mem[load_entry] <= load_len;
            id_mem[load_entry]  <= load_id;
        end
    end

    ////////////////////////////////////////
    // Read port

    // Asynchronous lookup for the matcher
    assign entry_word = word_mem[entry_idx][word_idx];
    assign entry_len  = len_mem[entry_idx];
    assign entry_id   = id_mem[entry_idx];

endmodule

// ==== hw/match_scoreboard.sv ====
/* Match scoreboard */

`timescale 1ns/10ps

module match_scoreboard import pkt_chk_pkg::*; (
    input  logic                axis_packet_in_monitor,
    input  logic                reset,
    input  logic                clear,
    input  logic                mark,
    input  entry_idx_t          mark_idx,
    output logic [max_pkts-1:0] received_mask,
    output match_cnt_t          match_count
);

    // One bit per table entry already matched
    always_ff @(posedge axis_packet_in_monitor) begin
        if (reset || clear) begin
            received_mask <= '0;
        end else if (mark) begin
            received_mask[mark_idx] <= 1'b1;
        end
    end

    // Running total of matched frames
    always_ff @(posedge axis_packet_in_monitor) begin
        if (reset || clear) begin
            match_count <= '0;
        end else if (mark) begin
            match_count <= match_count + match_cnt_t'(1);
        end
    end

endmodule

// ==== hw/pkt_match_ctrl.sv ====
/* Frame to table match controller */

`timescale 1ns/10ps

module pkt_match_ctrl import pkt_chk_pkg::*; (
    input  logic                axis_packet_in_monitor,
    input  logic                reset,
    rx_frame_if.matcher         frame,
    input  entry_cnt_t          num_expected,
    input  logic [max_pkts-1:0] received_mask,
    output entry_idx_t          entry_idx,
    output word_idx_t           word_idx,
    input  data_t               entry_word,
    input  blen_t               entry_len,
    input  pkt_id_t             entry_id,
    output logic                mark,
    output entry_idx_t          mark_idx,
    output logic                match_valid,
    output logic                miss_valid,
    output entry_idx_t          match_idx
);

    match_state_t state;
    entry_cnt_t   scan_pos;
    word_idx_t    cur_word;
    blen_t        remaining;
    data_t        byte_mask;
    logic         header_ok;
    logic         word_diff;
    logic         last_entry;

    assign entry_idx = entry_idx_t'(scan_pos);
    assign word_idx  = cur_word;
    assign frame.rd_word_idx   = cur_word;
    assign frame.frame_release = (state == st_release);
    assign mark_idx = match_idx;

    ////////////////////////////////////////
    // Compare datapath

    assign header_ok  = (entry_len == frame.frame_len) && (entry_id == frame.frame_id);
    assign last_entry = (scan_pos + entry_cnt_t'(1)) >= num_expected;
    // Bytes of the frame from the current word onwards
    assign remaining  = frame.frame_len - blen_t'(cur_word) * blen_t'(word_bytes);

    // Lanes past the frame length are ignored
    always_comb begin
        for (int b = 0; b < word_bytes; b++) begin
            byte_mask[b*8 +: 8] = (blen_t'(b) < remaining) ? 8'hff : 8'h00;
        end
    end

    assign word_diff = |((frame.rd_word ^ entry_word) & byte_mask);

    ////////////////////////////////////////
    // Scan FSM

    always_ff @(posedge axis_packet_in_monitor) begin
        if (reset) begin
            state       <= st_idle;
            scan_pos    <= '0;
            cur_word    <= '0;
            mark        <= 1'b0;
            match_valid <= 1'b0;
            miss_valid  <= 1'b0;
        end else begin
            mark        <= 1'b0;
            match_valid <= 1'b0;
            miss_valid  <= 1'b0;
            case (state)
                st_idle: begin
                    if (frame.frame_ready) begin
                        scan_pos <= '0;
                        state    <= st_entry_check;
                    end
                end
                st_entry_check: begin
                    cur_word <= '0;
                    if (scan_pos >= num_expected) begin
                        state <= st_report_miss;
                    end else if (received_mask[entry_idx] || !header_ok) begin
                        if (last_entry) begin
                            state <= st_report_miss;
                        end else begin
                            scan_pos <= scan_pos + entry_cnt_t'(1);
                        end
                    end else if (frame.frame_len == '0) begin
                        state <= st_report_match;
                    end else begin
                        state <= st_word_compare;
                    end
                end
                st_word_compare: begin
                    if (word_diff) begin
                        if (last_entry) begin
                            state <= st_report_miss;
                        end else begin
                            scan_pos <= scan_pos + entry_cnt_t'(1);
                            state    <= st_entry_check;
                        end
                    end else if (remaining <= blen_t'(word_bytes)) begin
                        state <= st_report_match;
                    end else begin
                        cur_word <= cur_word + word_idx_t'(1);
                    end
                end
                // Result pulses line up with the frame handback
                st_report_match: begin
                    mark        <= 1'b1;
                    match_valid <= 1'b1;
                    state       <= st_release;
                end
                st_report_miss: begin
                    miss_valid <= 1'b1;
                    state      <= st_release;
                end
                st_release: state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    // Index of the matched entry
    always_ff @(posedge axis_packet_in_monitor) begin
        if (state == st_report_match) begin
            match_idx <= entry_idx;
        end
    end

endmodule

// ==== hw/pkt_chk_top.sv ====
/* Packet checker top level */

`timescale 1ns/10ps

module pkt_chk_top import pkt_chk_pkg::*; (
    input  logic                axis_packet_in_monitor,
    input  logic                reset,
    // Stream in
    input  logic                tvalid,
    input  logic                tlast,
    input  data_t               tdata,
    input  keep_t               tkeep,
    input  pkt_id_t             packet_in_id,
    output logic                tready,
    // Table load
    input  logic                load_en,
    input  entry_idx_t          load_entry,
    input  word_idx_t           load_word,
    input  data_t               load_data,
    input  logic                load_len_en,
    input  blen_t               load_len,
    input  pkt_id_t             load_id,
    input  entry_cnt_t          num_expected,
    input  logic                clear,
    // Results
    output logic                match_valid,
    output logic                miss_valid,
    output entry_idx_t          match_idx,
    output logic [max_pkts-1:0] received_mask,
    output match_cnt_t          match_count
);

    entry_idx_t entry_idx;
    word_idx_t  word_idx;
    data_t      entry_word;
    blen_t      entry_len;
    pkt_id_t    entry_id;
    logic       mark;
    entry_idx_t mark_idx;

    rx_frame_if frame_bus ();

    pkt_assembler u_assembler (
        .axis_packet_in_monitor (axis_packet_in_monitor),
        .reset                  (reset),
        .tvalid                 (tvalid),
        .tlast                  (tlast),
        .tdata                  (tdata),
        .tkeep                  (tkeep),
        .packet_in_id           (packet_in_id),
        .tready                 (tready),
        .frame                  (frame_bus.assembler)
    );

    expected_table u_table (
        .axis_packet_in_monitor (axis_packet_in_monitor),
        .load_en                (load_en),
        .load_len_en            (load_len_en),
        .load_entry             (load_entry),
        .load_word              (load_word),
        .load_data              (load_data),
        .load_len               (load_len),
        .load_id                (load_id),
        .entry_idx              (entry_idx),
        .word_idx               (word_idx),
        .entry_word             (entry_word),
        .entry_len              (entry_len),
        .entry_id               (entry_id)
    );

    match_scoreboard u_scoreboard (
        .axis_packet_in_monitor (axis_packet_in_monitor),
        .reset                  (reset),
        .clear                  (clear),
        .mark                   (mark),
        .mark_idx               (mark_idx),
        .received_mask          (received_mask),
        .match_count            (match_count)
    );

    pkt_match_ctrl u_match_ctrl (
        .axis_packet_in_monitor (axis_packet_in_monitor),
        .reset                  (reset),
        .frame                  (frame_bus.matcher),
        .num_expected           (num_expected),
        .received_mask          (received_mask),
        .entry_idx              (entry_idx),
        .word_idx               (word_idx),
        .entry_word             (entry_word),
        .entry_len              (entry_len),
        .entry_id               (entry_id),
        .mark                   (mark),
        .mark_idx               (mark_idx),
        .match_valid            (match_valid),
        .miss_valid             (miss_valid),
        .match_idx              (match_idx)
    );

endmodule

// ==== sim/pkt_chk_model.svh ====
/* Packet checker reference model */

// Lowest unreceived entry equal to the frame, or -1 for a miss
function automatic int ref_match(input frame_bits_t fr,
                                 input int len,
                                 input pkt_id_t id,
                                 input frame_bits_t tbl [max_pkts],
                                 input int tbl_lens [max_pkts],
                                 input pkt_id_t tbl_ids [max_pkts],
                                 input logic [max_pkts-1:0] mask,
                                 input int num_live);
    int   result;
    logic same;
    result = -1;
    // Walk downwards so the lowest index is the one left in result
    for (int e = max_pkts - 1; e >= 0; e--) begin
        same = (e < num_live) && !mask[e] && (tbl_lens[e] == len) && (tbl_ids[e] == id);
        for (int b = 0; b < mtu_bytes; b++) begin
            // Bytes at or past the length never count
            if (b < len && fr[b*8 +: 8] != tbl[e][b*8 +: 8]) begin
                same = 1'b0;
            end
        end
        if (same) begin
            result = e;
        end
    end
    return result;
endfunction

// Write all words and the header of the first n entries
task automatic load_table(input int n);
    for (int e = 0; e < n; e++) begin
        for (int w = 0; w < mtu_words; w++) begin
            @(posedge axis_packet_in_monitor);
            load_en     <= 1'b1;
            load_len_en <= 1'b0;
            load_entry  <= entry_idx_t'(e);
            load_word   <= word_idx_t'(w);
            load_data   <= tbl_bits[e][w*word_bytes*8 +: word_bytes*8];
        end
        @(posedge axis_packet_in_monitor);
        load_en     <= 1'b0;
        load_len_en <= 1'b1;
        load_len    <= blen_t'(tbl_lens[e]);
        load_id     <= tbl_ids[e];
    end
    @(posedge axis_packet_in_monitor);
    load_len_en  <= 1'b0;
    num_expected <= entry_cnt_t'(n);
    live_cnt = n;
endtask

// One frame on the stream, word held while tready is low
task automatic send_frame(input frame_bits_t fr,
                          input int len,
                          input pkt_id_t id,
                          input int gap_max);
    int nw;
    int tail;
    int gap;
    nw   = (len + word_bytes - 1) / word_bytes;
    tail = len - (nw - 1) * word_bytes;
    for (int w = 0; w < nw; w++) begin
        gap = (gap_max > 0) ? int'($urandom % (gap_max + 1)) : 0;
        repeat (gap) begin
            @(posedge axis_packet_in_monitor);
            tvalid <= 1'b0;
        end
        @(posedge axis_packet_in_monitor);
        tvalid <= 1'b1;
        tdata  <= fr[w*word_bytes*8 +: word_bytes*8];
        tlast  <= (w == nw - 1);
        tkeep  <= (w == nw - 1) ? keep_t'((1 << tail) - 1) : keep_t'((1 << word_bytes) - 1);
        // Id is only sampled with the last word, so earlier words carry noise
        packet_in_id <= (w == nw - 1) ? id : pkt_id_t'($urandom);
        @(negedge axis_packet_in_monitor);
        while (!tready) begin
            @(negedge axis_packet_in_monitor);
        end
    end
    @(posedge axis_packet_in_monitor);
    tvalid <= 1'b0;
    tlast  <= 1'b0;
endtask

// ==== sim/pkt_chk_tb.sv ====
/* Packet checker testbench */

`timescale 1ns/10ps

module pkt_chk_tb import pkt_chk_pkg::*; ();

    typedef logic [mtu_bytes*8-1:0] frame_bits_t;

    localparam int clk_period     = 40;
    localparam int max_gap        = 3;
    localparam int max_latency    = 3 + max_pkts * (1 + mtu_words);
    localparam int frame_cycles   = max_latency + mtu_words * (max_gap + 2) + 4;
    localparam int load_cycles    = max_pkts * (mtu_words + 1) + 2;
    localparam int total_frames   = 35;
    localparam int total_loads    = 5;
    localparam int timeout_cycles = total_frames * frame_cycles + total_loads * load_cycles + 500;

    logic                axis_packet_in_monitor;
    logic                reset;
    logic                tvalid;
    logic                tlast;
    data_t               tdata;
    keep_t               tkeep;
    pkt_id_t             packet_in_id;
    logic                tready;
    logic                load_en;
    entry_idx_t          load_entry;
    word_idx_t           load_word;
    data_t               load_data;
    logic                load_len_en;
    blen_t               load_len;
    pkt_id_t             load_id;
    entry_cnt_t          num_expected;
    logic                clear;
    logic                match_valid;
    logic                miss_valid;
    entry_idx_t          match_idx;
    logic [max_pkts-1:0] received_mask;
    match_cnt_t          match_count;

    // Software copy of the table
    frame_bits_t tbl_bits [max_pkts];
    int          tbl_lens [max_pkts];
    pkt_id_t     tbl_ids  [max_pkts];
    int          live_cnt;
    int          order    [max_pkts];

    // Expected scoreboard state and per-frame results
    logic [max_pkts-1:0] model_mask;
    match_cnt_t          model_count;
    int                  exp_idx_q   [$];
    logic [max_pkts-1:0] exp_mask_q  [$];
    match_cnt_t          exp_count_q [$];
    int                  sent_count;
    int                  done_count;

    `include "pkt_chk_model.svh"

    pkt_chk_top dut (
        .axis_packet_in_monitor (axis_packet_in_monitor),
        .reset                  (reset),
        .tvalid                 (tvalid),
        .tlast                  (tlast),
        .tdata                  (tdata),
        .tkeep                  (tkeep),
        .packet_in_id           (packet_in_id),
        .tready                 (tready),
        .load_en                (load_en),
        .load_entry             (load_entry),
        .load_word              (load_word),
        .load_data              (load_data),
        .load_len_en            (load_len_en),
        .load_len               (load_len),
        .load_id                (load_id),
        .num_expected           (num_expected),
        .clear                  (clear),
        .match_valid            (match_valid),
        .miss_valid             (miss_valid),
        .match_idx              (match_idx),
        .received_mask          (received_mask),
        .match_count            (match_count)
    );

    initial begin
        axis_packet_in_monitor = 1'b0;
        forever #(clk_period / 2) axis_packet_in_monitor = ~axis_packet_in_monitor;
    end

    ////////////////////////////////////////
    // Helpers

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1, "check on %s failed", name);
        end
    endtask

    function automatic frame_bits_t random_frame();
        frame_bits_t f;
        for (int i = 0; i < mtu_bytes / 4; i++) begin
            f[i*32 +: 32] = $urandom;
        end
        return f;
    endfunction

    function automatic void fill_entry(input int e, input int len);
        tbl_bits[e] = random_frame();
        tbl_lens[e] = len;
        tbl_ids[e]  = pkt_id_t'($urandom);
    endfunction

    // Fisher-Yates over the entry indices
    function automatic void shuffle_order();
        int j;
        int tmp;
        for (int i = 0; i < max_pkts; i++) begin
            order[i] = i;
        end
        for (int i = max_pkts - 1; i > 0; i--) begin
            j        = int'($urandom % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
    endfunction

    task automatic send_and_expect(input frame_bits_t fr, input int len, input pkt_id_t id,
                                   input int gap_max);
        int exp_idx;
        exp_idx = ref_match(fr, len, id, tbl_bits, tbl_lens, tbl_ids, model_mask, live_cnt);
        if (exp_idx >= 0) begin
            model_mask[exp_idx] = 1'b1;
            model_count         = model_count + match_cnt_t'(1);
        end
        exp_idx_q.push_back(exp_idx);
        exp_mask_q.push_back(model_mask);
        exp_count_q.push_back(model_count);
        sent_count++;
        send_frame(fr, len, id, gap_max);
    endtask

    task automatic send_entry(input int e, input int gap_max);
        send_and_expect(tbl_bits[e], tbl_lens[e], tbl_ids[e], gap_max);
    endtask

    task automatic wait_results();
        while (done_count != sent_count) begin
            @(posedge axis_packet_in_monitor);
        end
    endtask

    task automatic clear_results();
        wait_results();
        @(posedge axis_packet_in_monitor);
        clear <= 1'b1;
        @(posedge axis_packet_in_monitor);
        clear <= 1'b0;
        model_mask  = '0;
        model_count = '0;
        @(negedge axis_packet_in_monitor);
        check_value("received_mask", 64'(received_mask), 64'(0));
        check_value("match_count", 64'(match_count), 64'(0));
    endtask

    ////////////////////////////////////////
    // Result checker

    initial begin : result_check
        int                  exp_idx;
        logic [max_pkts-1:0] exp_mask;
        match_cnt_t          exp_count;
        forever begin
            @(negedge axis_packet_in_monitor);
            if (match_valid || miss_valid) begin
                if (exp_idx_q.size() == 0) begin
                    $display("Result pulse at %0t ns with no frame outstanding", $time);
                    $display("Test failures found");
                    $fatal(1, "unexpected result pulse");
                end else begin
                    exp_idx   = exp_idx_q.pop_front();
                    exp_mask  = exp_mask_q.pop_front();
                    exp_count = exp_count_q.pop_front();
                    check_value("match_valid/miss_valid", 64'({match_valid, miss_valid}),
                                64'((exp_idx >= 0) ? 2'b10 : 2'b01));
                    if (exp_idx >= 0) begin
                        check_value("match_idx", 64'(match_idx), 64'(exp_idx));
                    end
                    // Scoreboard lags the pulse by one cycle
                    @(negedge axis_packet_in_monitor);
                    check_value("received_mask", 64'(received_mask), 64'(exp_mask));
                    check_value("match_count", 64'(match_count), 64'(exp_count));
                    check_value("tready", 64'(tready), 64'(1));
                    done_count++;
                end
            end
        end
    end

    initial begin : watchdog
        #(timeout_cycles * clk_period);
        $display("Watchdog expired after %0d cycles, the run did not finish", timeout_cycles);
        $display("Test failures found");
        $fatal(1, "timeout");
    end

    ////////////////////////////////////////
    // Stimulus

    initial begin : stimulus
        int          len;
        int          pos;
        int          nw;
        frame_bits_t fr;

        void'($urandom(32'h2773_a6fd));
        model_mask   = '0;
        model_count  = '0;
        sent_count   = 0;
        done_count   = 0;
        live_cnt     = 0;
        reset        <= 1'b1;
        tvalid       <= 1'b0;
        tlast        <= 1'b0;
        tdata        <= '0;
        tkeep        <= '0;
        packet_in_id <= '0;
        load_en      <= 1'b0;
        load_entry   <= '0;
        load_word    <= '0;
        load_data    <= '0;
        load_len_en  <= 1'b0;
        load_len     <= '0;
        load_id      <= '0;
        num_expected <= '0;
        clear        <= 1'b0;
        repeat (8) @(posedge axis_packet_in_monitor);
        reset <= 1'b0;
        @(negedge axis_packet_in_monitor);
        check_value("tready", 64'(tready), 64'(1));
        check_value("match_valid", 64'(match_valid), 64'(0));
        check_value("miss_valid", 64'(miss_valid), 64'(0));
        check_value("received_mask", 64'(received_mask), 64'(0));
        check_value("match_count", 64'(match_count), 64'(0));

        // Shuffled matches, then a repeat that has to miss
        for (int e = 0; e < max_pkts; e++) begin
            fill_entry(e, 1 + int'($urandom % mtu_bytes));
        end
        load_table(max_pkts);
        shuffle_order();
        for (int i = 0; i < max_pkts; i++) begin
            send_entry(order[i], 0);
        end
        send_entry(3, 0);
        wait_results();

        // Near misses on a four entry table
        clear_results();
        for (int e = 0; e < 4; e++) begin
            fill_entry(e, 1 + int'($urandom % mtu_bytes));
        end
        tbl_lens[0] = word_bytes * int'($urandom % 7) + 1 + int'($urandom % 7);
        load_table(4);
        len = tbl_lens[0];
        send_and_expect(tbl_bits[0], len, pkt_id_t'(tbl_ids[0] + pkt_id_t'(1)), 0);
        send_and_expect(tbl_bits[0], len + 1, tbl_ids[0], 0);
        fr  = tbl_bits[0];
        pos = int'($urandom % len);
        fr[pos*8 +: 8] = ~fr[pos*8 +: 8];
        send_and_expect(fr, len, tbl_ids[0], 0);
        // Unused lanes of the last word
        fr = tbl_bits[0];
        nw = (len + word_bytes - 1) / word_bytes;
        for (int b = len; b < nw * word_bytes; b++) begin
            fr[b*8 +: 8] = ~fr[b*8 +: 8];
        end
        send_and_expect(fr, len, tbl_ids[0], 0);
        wait_results();

        // Every tail length
        clear_results();
        for (int e = 0; e < max_pkts; e++) begin
            fill_entry(e, e + 1 + word_bytes * int'($urandom % mtu_words));
        end
        load_table(max_pkts);
        for (int e = 0; e < max_pkts; e++) begin
            send_entry(e, 0);
        end
        wait_results();

        // Duplicate entries 1 and 6
        clear_results();
        tbl_bits[6] = tbl_bits[1];
        tbl_lens[6] = tbl_lens[1];
        tbl_ids[6]  = tbl_ids[1];
        load_table(max_pkts);
        repeat (3) send_entry(1, 0);
        wait_results();

        // Gapped stream against back-pressure, then matches after clear
        clear_results();
        for (int e = 0; e < max_pkts; e++) begin
            fill_entry(e, 1 + int'($urandom % mtu_bytes));
        end
        load_table(max_pkts);
        shuffle_order();
        for (int i = 0; i < max_pkts; i++) begin
            send_entry(order[i], max_gap);
        end
        clear_results();
        for (int e = 0; e < 3; e++) begin
            send_entry(e, max_gap);
        end
        wait_results();

        @(negedge axis_packet_in_monitor);
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+sim
hw/pkt_chk_pkg.sv
hw/rx_frame_if.sv
hw/pkt_assembler.sv
hw/expected_table.sv
hw/match_scoreboard.sv
hw/pkt_match_ctrl.sv
hw/pkt_chk_top.sv
sim/pkt_chk_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the packet checker testbench with Verilator

set -u

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --timing -j 0 --top-module pkt_chk_tb -Mdir obj_dir -f files.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vpkt_chk_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation completed"
exit 0
